// ==== dv/execute_stim.txt ====
// unit_inst_rs1_rs2_imm_pc_rob_pd_rd_flush_exprdv_expa_expb, all hex, one record per line
// unit 0 alu 1 mul 2 div 3 br 4 mem, flush 1 with start 2 a cycle later, mem exprdv is wdata
0_40000033_00000003_00000005_00000000_00000000_01_11_05_0_FFFFFFFE_00000000_00
0_00003013_00000001_00000000_FFFFFFFF_00000000_02_12_06_0_00000001_00000000_00
0_00001017_00000000_00000000_00000000_00000100_03_13_07_0_00001100_00000000_00
1_02000033_00000007_FFFFFFFD_00000000_00000000_04_14_08_0_FFFFFFEB_00000000_00
1_02001033_80000000_80000000_00000000_00000000_05_15_09_0_40000000_00000000_00
1_02002033_FFFFFFFF_FFFFFFFF_00000000_00000000_06_16_0A_0_FFFFFFFF_00000000_00
1_02003033_FFFFFFFF_FFFFFFFF_00000000_00000000_07_17_0B_0_FFFFFFFE_00000000_00
2_02004033_FFFFFFEC_00000003_00000000_00000000_08_18_0C_0_FFFFFFFA_00000000_00
2_02005033_12345678_00000000_00000000_00000000_09_19_0D_0_FFFFFFFF_00000000_00
2_02006033_FFFFFFF9_00000000_00000000_00000000_0A_1A_0E_0_FFFFFFF9_00000000_00
2_02007033_00000064_00000007_00000000_00000000_0B_1B_0F_0_00000002_00000000_00
2_02004033_80000000_FFFFFFFF_00000000_00000000_0C_1C_10_0_80000000_00000000_00
3_00000063_00000042_00000042_00000010_00001000_0D_1D_00_0_00000000_00001010_01
3_00006063_FFFFFFFF_00000001_FFFFFFF0_00002000_0E_1E_00_0_00000000_00000000_00
3_00000067_00003001_00000000_00000004_00000400_0F_1F_01_0_00000404_00003004_01
4_00002003_00001000_00000000_00000008_00000000_10_20_02_0_00000000_00001008_00
4_00000023_00001000_000000AB_00000003_00000000_11_21_00_0_AB000000_00001003_08
4_00001023_00001000_0000BEEF_00000006_00000000_12_22_00_0_BEEF0000_00001006_0C
1_02000033_00000002_00000003_00000000_00000000_13_23_03_2_00000006_00000000_00
0_00000033_00000001_00000001_00000000_00000000_14_24_04_1_00000002_00000000_00

// ==== sources.f ====
+incdir+verilog
verilog/rv32i_types.sv
verilog/fu_alu.sv
verilog/fu_mult.sv
verilog/fu_div_rem.sv
verilog/fu_br.sv
verilog/fu_mem.sv
verilog/execute.sv
dv/execute_tb.sv

// ==== Bender.yml ====
package:
  name: execute_stage

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv32i_types.sv
      - verilog/fu_alu.sv
      - verilog/fu_mult.sv
      - verilog/fu_div_rem.sv
      - verilog/fu_br.sv
      - verilog/fu_mem.sv
      - verilog/execute.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/execute_tb.sv

// ==== dv/execute_tb.sv ====
`include "exec_consts.svh"

module execute_tb
import rv32i_types::*;
();

    localparam int max_recs = 64;
    localparam int rec_bits = 264;

    localparam logic [3:0] unit_alu = 4'd0;
    localparam logic [3:0] unit_mul = 4'd1;
    localparam logic [3:0] unit_div = 4'd2;
    localparam logic [3:0] unit_br  = 4'd3;
    localparam logic [3:0] unit_mem = 4'd4;

    // one line of the stimulus file
    typedef struct packed {
        logic [3:0]  unit;
        logic [31:0] inst;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] imm;
        logic [31:0] pc;
        logic [7:0]  rob_idx;
        logic [7:0]  pd;
        logic [7:0]  rd;
        logic [3:0]  flush_mode;
        logic [31:0] exp_rd_v;
        logic [31:0] exp_a;
        logic [7:0]  exp_b;
    } stim_rec_t;

    logic                      clk;
    logic                      rst;
    logic                      flush;
    logic                      start_add;
    logic                      start_mul;
    logic                      start_div;
    logic                      start_br;
    logic                      start_mem;
    issue_t                    issue_add;
    issue_t                    issue_mul;
    issue_t                    issue_div;
    issue_t                    issue_br;
    issue_t                    issue_mem;
    logic [`MEM_IDX_WIDTH-1:0] mem_idx_in;
    cdb_t                      cdb_add;
    cdb_t                      cdb_mul;
    cdb_t                      cdb_div;
    cdb_t                      cdb_br;
    mem_req_t                  mem_req;
    logic                      busy_add;
    logic                      busy_mul;
    logic                      busy_div;
    logic                      busy_br;
    logic                      busy_mem;

    logic [rec_bits-1:0] stim_raw [0:max_recs-1];
    int                  n_recs;
    int                  n_checks;
    int                  n_mismatch;
    int                  n_other;

    execute dut (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // budget grows with the number of records
    initial begin
        #1;
        repeat (n_recs * 8 + 50) @(posedge clk);
        $display("Timeout: stimulus did not finish within %0d cycles", n_recs * 8 + 50);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        n_checks++;
        assert (act === exp) else begin
            n_mismatch++;
            $display("Mismatch at time %0t: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        n_checks++;
        assert (cond === 1'b1) else begin
            n_other++;
            $display("Error at time %0t: %s", $time, what);
        end
    endtask

    task automatic expect_no_valid(input string where);
        expect_true({cdb_add.valid, cdb_mul.valid, cdb_div.valid, cdb_br.valid,
                     mem_req.valid} === 5'b0, {"a valid output is high ", where});
    endtask

    task automatic expect_no_busy(input string where);
        expect_true({busy_add, busy_mul, busy_div, busy_br, busy_mem} === 5'b0,
                    {"a busy output is high ", where});
    endtask

    task automatic verify_tags(input string bus, input cdb_t c, input stim_rec_t r);
        compare_value({bus, ".rob_idx"}, r.rob_idx[`ROB_ADDR_WIDTH-1:0], c.rob_idx);
        compare_value({bus, ".pd"}, r.pd[`PHYS_REG_BITS-1:0], c.pd);
        compare_value({bus, ".rd"}, r.rd[`ARCH_REG_BITS-1:0], c.rd);
        compare_value({bus, ".inst"}, r.inst, c.inst);
    endtask

    task automatic clear_inputs();
        start_add = 1'b0;
        start_mul = 1'b0;
        start_div = 1'b0;
        start_br  = 1'b0;
        start_mem = 1'b0;
        flush     = 1'b0;
    endtask

    // the same immediate feeds every immediate field
    function automatic issue_t make_issue(input stim_rec_t r);
        issue_t iss;
        iss                   = '0;
        iss.rs1_v             = r.rs1;
        iss.rs2_v             = r.rs2;
        iss.decode_info.pc    = r.pc;
        iss.decode_info.inst  = r.inst;
        iss.decode_info.i_imm = r.imm;
        iss.decode_info.s_imm = r.imm;
        iss.decode_info.b_imm = r.imm;
        iss.rob_idx           = r.rob_idx[`ROB_ADDR_WIDTH-1:0];
        iss.pd                = r.pd[`PHYS_REG_BITS-1:0];
        iss.rd                = r.rd[`ARCH_REG_BITS-1:0];
        return iss;
    endfunction

    task automatic apply_record(input stim_rec_t r);
        issue_t iss;
        iss        = make_issue(r);
        mem_idx_in = r.rob_idx[`MEM_IDX_WIDTH-1:0];
        flush      = (r.flush_mode == 4'd1);
        case (r.unit)
            unit_alu: begin
                issue_add = iss;
                start_add = 1'b1;
            end
            unit_mul: begin
                issue_mul = iss;
                start_mul = 1'b1;
            end
            unit_div: begin
                issue_div = iss;
                start_div = 1'b1;
            end
            unit_br: begin
                issue_br = iss;
                start_br = 1'b1;
            end
            unit_mem: begin
                issue_mem = iss;
                start_mem = 1'b1;
            end
            default: expect_true(1'b0, "stimulus record has an unknown unit code");
        endcase
        // a start under flush goes to every unit
        if (flush) begin
            start_add = 1'b1;
            start_mul = 1'b1;
            start_div = 1'b1;
            start_br  = 1'b1;
            start_mem = 1'b1;
        end
    endtask

    // single-cycle units answer in the start cycle
    task automatic verify_comb_unit(input stim_rec_t r);
        case (r.unit)
            unit_alu: begin
                expect_true(cdb_add.valid, "cdb_add not valid in the start cycle");
                compare_value("cdb_add.rd_v", r.exp_rd_v, cdb_add.rd_v);
                compare_value("cdb_add.pc_select", 32'd0, cdb_add.pc_select);
                verify_tags("cdb_add", cdb_add, r);
            end
            unit_br: begin
                expect_true(cdb_br.valid, "cdb_br not valid in the start cycle");
                compare_value("cdb_br.rd_v", r.exp_rd_v, cdb_br.rd_v);
                compare_value("cdb_br.pc_select", r.exp_b[0], cdb_br.pc_select);
                compare_value("cdb_br.pc_branch", r.exp_a, cdb_br.pc_branch);
                verify_tags("cdb_br", cdb_br, r);
            end
            unit_mem: begin
                expect_true(mem_req.valid, "mem_req not valid in the start cycle");
                compare_value("mem_req.addr", r.exp_a, mem_req.addr);
                compare_value("mem_req.wdata", r.exp_rd_v, mem_req.wdata);
                compare_value("mem_req.wmask", r.exp_b[3:0], mem_req.wmask);
                compare_value("mem_req.mem_idx", r.rob_idx[`MEM_IDX_WIDTH-1:0], mem_req.mem_idx);
                // only stores carry a byte mask
                compare_value("mem_req.store", r.exp_b[3:0] != 4'b0000, mem_req.store);
            end
            default: begin
            end
        endcase
    endtask

    task automatic follow_muldiv(input stim_rec_t r);
        string bus;
        cdb_t  c;
        logic  busy;
        bus = (r.unit == unit_mul) ? "cdb_mul" : "cdb_div";
        for (int k = 1; k <= `MULDIV_LATENCY; k++) begin
            #2;
            c    = (r.unit == unit_mul) ? cdb_mul : cdb_div;
            busy = (r.unit == unit_mul) ? busy_mul : busy_div;
            expect_true(busy, {"busy is low while the ", bus, " result is pending"});
            if (k < `MULDIV_LATENCY) begin
                expect_true(!c.valid, {bus, " became valid before the fixed latency"});
            end else begin
                expect_true(c.valid, {"no valid on ", bus, " four cycles after start"});
                compare_value({bus, ".rd_v"}, r.exp_rd_v, c.rd_v);
                verify_tags(bus, c, r);
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic watch_quiet(input string where, input int cycles);
        repeat (cycles) begin
            #2;
            expect_no_valid(where);
            expect_no_busy(where);
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_record(input stim_rec_t r);
        logic is_muldiv;
        is_muldiv = (r.unit == unit_mul) || (r.unit == unit_div);
        while (busy_mul || busy_div) begin
            @(posedge clk);
            #1;
        end
        apply_record(r);
        #2;
        if (r.flush_mode == 4'd1) begin
            expect_no_valid("when start coincides with flush");
        end else if (!is_muldiv) begin
            verify_comb_unit(r);
        end
        @(posedge clk);
        #1;
        clear_inputs();
        if (r.flush_mode == 4'd1) begin
            watch_quiet("after a start under flush", `MULDIV_LATENCY + 1);
        end else if (is_muldiv) begin
            // flush one cycle after start
            if (r.flush_mode == 4'd2) begin
                flush = 1'b1;
                #2;
                expect_no_valid("during flush");
                @(posedge clk);
                #1;
                flush = 1'b0;
            end
            if (r.flush_mode == 4'd0) begin
                follow_muldiv(r);
            end else begin
                watch_quiet("after a cancelled multi-cycle start", `MULDIV_LATENCY + 1);
            end
        end
    endtask

    initial begin
        stim_rec_t rec;
        n_checks   = 0;
        n_mismatch = 0;
        n_other    = 0;
        rst        = 1'b1;
        issue_add  = '0;
        issue_mul  = '0;
        issue_div  = '0;
        issue_br   = '0;
        issue_mem  = '0;
        mem_idx_in = '0;
        clear_inputs();
        $readmemh("dv/execute_stim.txt", stim_raw);
        n_recs = 0;
        while (n_recs < max_recs && !$isunknown(stim_raw[n_recs])) begin
            n_recs++;
        end
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        watch_quiet("right after reset", 2);
        if (n_recs == 0) begin
            expect_true(1'b0, "no stimulus records were loaded");
        end
        for (int i = 0; i < n_recs; i++) begin
            rec = stim_rec_t'(stim_raw[i]);
            run_record(rec);
        end
        $display("records: %0d, checks: %0d, mismatches: %0d, other errors: %0d",
                 n_recs, n_checks, n_mismatch, n_other);
        if (n_mismatch == 0 && n_other == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog/execute.sv ====
`include "exec_consts.svh"

module execute
import rv32i_types::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,
    input  logic                      start_add,
    input  issue_t                    issue_add,
    input  logic                      start_mul,
    input  issue_t                    issue_mul,
    input  logic                      start_div,
    input  issue_t                    issue_div,
    input  logic                      start_br,
    input  issue_t                    issue_br,
    input  logic                      start_mem,
    input  issue_t                    issue_mem,
    input  logic [`MEM_IDX_WIDTH-1:0] mem_idx_in,
    output cdb_t                      cdb_add,
    output cdb_t                      cdb_mul,
    output cdb_t                      cdb_div,
    output cdb_t                      cdb_br,
    output mem_req_t                  mem_req,
    output logic                      busy_add,
    output logic                      busy_mul,
    output logic                      busy_div,
    output logic                      busy_br,
    output logic                      busy_mem
);

    typedef struct packed {
        logic [`ROB_ADDR_WIDTH-1:0] rob_idx;
        logic [`PHYS_REG_BITS-1:0]  pd;
        logic [`ARCH_REG_BITS-1:0]  rd;
        logic [31:0]                inst;
    } fu_tag_t;

    logic                       go_add;
    logic                       go_mul;
    logic                       go_div;
    logic                       go_br;
    logic                       go_mem;
    fu_tag_t                    tag_mul;
    fu_tag_t                    tag_div;
    logic [`MULDIV_LATENCY-1:0] inflight_mul;
    logic [`MULDIV_LATENCY-1:0] inflight_div;
    logic [31:0]                rd_v_add;
    logic [31:0]                rd_v_mul;
    logic [31:0]                rd_v_div;
    logic [31:0]                rd_v_br;
    logic                       valid_add;
    logic                       valid_mul;
    logic                       valid_div;
    logic                       valid_br;
    logic                       pc_select;
    logic [31:0]                pc_branch;
    mem_req_t                   req_mem;

    function automatic fu_tag_t tag_of(input issue_t iss);
        fu_tag_t t;
        t.rob_idx = iss.rob_idx;
        t.pd      = iss.pd;
        t.rd      = iss.rd;
        t.inst    = iss.decode_info.inst;
        return t;
    endfunction

    function automatic cdb_t make_cdb(input logic vld, input fu_tag_t t, input logic [31:0] val);
        cdb_t rec;
        rec         = '0;
        rec.valid   = vld;
        rec.rob_idx = t.rob_idx;
        rec.pd      = t.pd;
        rec.rd      = t.rd;
        rec.rd_v    = val;
        rec.inst    = t.inst;
        return rec;
    endfunction

    // nothing new starts under flush
    assign go_add = start_add & ~flush;
    assign go_mul = start_mul & ~flush;
    assign go_div = start_div & ~flush;
    assign go_br  = start_br & ~flush;
    assign go_mem = start_mem & ~flush;

    // tags for the results that come back later
    always_ff @(posedge clk) begin
        if (go_mul) begin
            tag_mul <= tag_of(issue_mul);
        end
        if (go_div) begin
            tag_div <= tag_of(issue_div);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            inflight_mul <= '0;
            inflight_div <= '0;
        end else begin
            inflight_mul <= {inflight_mul[`MULDIV_LATENCY-2:0], go_mul};
            inflight_div <= {inflight_div[`MULDIV_LATENCY-2:0], go_div};
        end
    end

    assign busy_mul = |inflight_mul;
    assign busy_div = |inflight_div;
    // single-cycle units never stall
    assign busy_add = 1'b0;
    assign busy_br  = 1'b0;
    assign busy_mem = 1'b0;

    fu_alu u_alu (
        .issue (issue_add),
        .start (go_add),
        .rd_v  (rd_v_add),
        .valid (valid_add)
    );

    fu_mult u_mult (
        .clk    (clk),
        .rst    (rst),
        .start  (go_mul),
        .cancel (flush),
        .rs1_v  (issue_mul.rs1_v),
        .rs2_v  (issue_mul.rs2_v),
        .funct3 (muldiv_f3_e'(issue_mul.decode_info.inst[14:12])),
        .rd_v   (rd_v_mul),
        .valid  (valid_mul)
    );

    fu_div_rem u_div (
        .clk    (clk),
        .rst    (rst),
        .start  (go_div),
        .cancel (flush),
        .rs1_v  (issue_div.rs1_v),
        .rs2_v  (issue_div.rs2_v),
        .funct3 (muldiv_f3_e'(issue_div.decode_info.inst[14:12])),
        .rd_v   (rd_v_div),
        .valid  (valid_div)
    );

    fu_br u_br (
        .issue     (issue_br),
        .start     (go_br),
        .rd_v      (rd_v_br),
        .valid     (valid_br),
        .pc_select (pc_select),
        .pc_branch (pc_branch)
    );

    fu_mem u_mem (
        .issue      (issue_mem),
        .start      (go_mem),
        .mem_idx_in (mem_idx_in),
        .req        (req_mem)
    );

    always_comb begin
        cdb_add = make_cdb(valid_add, tag_of(issue_add), rd_v_add);
        cdb_mul = make_cdb(valid_mul, tag_mul, rd_v_mul);
        cdb_div = make_cdb(valid_div, tag_div, rd_v_div);
        cdb_br  = make_cdb(valid_br, tag_of(issue_br), rd_v_br);
        // only the branch record redirects fetch
        cdb_br.pc_select = pc_select;
        cdb_br.pc_branch = pc_branch;
        mem_req = req_mem;
        if (flush) begin
            cdb_add = '0;
            cdb_mul = '0;
            cdb_div = '0;
            cdb_br  = '0;
            mem_req = '0;
        end
    end

endmodule

// ==== verilog/fu_mem.sv ====
`include "exec_consts.svh"

module fu_mem
import rv32i_types::*;
(
    input  issue_t                    issue,
    input  logic                      start,
    input  logic [`MEM_IDX_WIDTH-1:0] mem_idx_in,
    output mem_req_t                  req
);

    logic        is_store;
    logic [31:0] addr;
    logic [1:0]  offset;
    mem_f3_e     width;

    assign is_store = issue.decode_info.inst[6:0] == op_store;
    assign width    = mem_f3_e'(issue.decode_info.inst[14:12]);
    assign addr     = issue.rs1_v + (is_store ? issue.decode_info.s_imm : issue.decode_info.i_imm);
    assign offset   = addr[1:0];

    always_comb begin
        req         = '0;
        req.valid   = start;
        req.addr    = addr;
        req.store   = is_store;
        req.mem_idx = mem_idx_in;
        if (is_store) begin
            // place sub-word data on its byte lanes
            case (width)
                mem_b: begin
                    req.wdata = issue.rs2_v << {offset, 3'b000};
                    req.wmask = 4'b0001 << offset;
                end
                mem_h: begin
                    req.wdata = issue.rs2_v << {offset[1], 4'b0000};
                    req.wmask = 4'b0011 << {offset[1], 1'b0};
                end
                default: begin
                    req.wdata = issue.rs2_v;
                    req.wmask = 4'b1111;
                end
            endcase
        end
    end

endmodule

// ==== verilog/fu_br.sv ====
module fu_br
import rv32i_types::*;
(
    input  issue_t      issue,
    input  logic        start,
    output logic [31:0] rd_v,
    output logic        valid,
    output logic        pc_select,
    output logic [31:0] pc_branch
);

    rv_opcode_e  opcode;
    branch_f3_e  funct3;
    logic        taken;
    logic [31:0] jalr_target;

    assign opcode = rv_opcode_e'(issue.decode_info.inst[6:0]);
    assign funct3 = branch_f3_e'(issue.decode_info.inst[14:12]);
    assign jalr_target = issue.rs1_v + issue.decode_info.i_imm;

    always_comb begin
        case (funct3)
            br_beq:  taken = issue.rs1_v == issue.rs2_v;
            br_bne:  taken = issue.rs1_v != issue.rs2_v;
            br_blt:  taken = $signed(issue.rs1_v) < $signed(issue.rs2_v);
            br_bge:  taken = $signed(issue.rs1_v) >= $signed(issue.rs2_v);
            br_bltu: taken = issue.rs1_v < issue.rs2_v;
            br_bgeu: taken = issue.rs1_v >= issue.rs2_v;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        pc_select = 1'b0;
        pc_branch = '0;
        rd_v      = '0;
        if (opcode == op_jalr) begin
            // jalr always redirects and links
            pc_select = start;
            pc_branch = jalr_target & 32'hffff_fffe;
            rd_v      = issue.decode_info.pc + 32'd4;
        end else if (taken) begin
            pc_select = start;
            pc_branch = issue.decode_info.pc + issue.decode_info.b_imm;
        end
    end

    assign valid = start;

endmodule

// ==== verilog/fu_div_rem.sv ====
module fu_div_rem
import rv32i_types::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic        cancel,
    input  logic [31:0] rs1_v,
    input  logic [31:0] rs2_v,
    input  muldiv_f3_e  funct3,
    output logic [31:0] rd_v,
    output logic        valid
);

    logic        op_signed;
    logic [31:0] mag_a;
    logic [31:0] mag_b;
    logic [31:0] rem_in;
    logic [31:0] quo_in;
    logic [31:0] dvs_in;
    logic [31:0] rem_nx;
    logic [31:0] quo_nx;
    logic [31:0] rem_q;
    logic [31:0] quo_q;
    logic [31:0] dvs_q;
    logic        neg_q;
    logic        neg_r;
    logic        is_rem_q;
    logic        active;
    logic [1:0]  step_cnt;
    logic        done;

    assign op_signed = (funct3 == md_div) || (funct3 == md_rem);
    assign mag_a = (op_signed && rs1_v[31]) ? -rs1_v : rs1_v;
    assign mag_b = (op_signed && rs2_v[31]) ? -rs2_v : rs2_v;

    // first eight bits retire in the start cycle
    always_comb begin
        if (start) begin
            rem_in = '0;
            quo_in = mag_a;
            dvs_in = mag_b;
        end else begin
            rem_in = rem_q;
            quo_in = quo_q;
            dvs_in = dvs_q;
        end
    end

    always_comb begin : restore
        logic [32:0] part;
        logic [31:0] q;
        part = {1'b0, rem_in};
        q    = quo_in;
        for (int i = 0; i < 8; i++) begin
            part = {part[31:0], q[31]};
            q    = {q[30:0], 1'b0};
            if (part >= {1'b0, dvs_in}) begin
                part = part - {1'b0, dvs_in};
                q[0] = 1'b1;
            end
        end
        rem_nx = part[31:0];
        quo_nx = q;
    end

    always_ff @(posedge clk) begin
        if (rst || cancel) begin
            active   <= 1'b0;
            step_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                active   <= 1'b1;
                step_cnt <= 2'd1;
            end else if (active) begin
                step_cnt <= step_cnt + 2'd1;
                if (step_cnt == 2'd3) begin
                    active <= 1'b0;
                    done   <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start || active) begin
            rem_q <= rem_nx;
            quo_q <= quo_nx;
        end
        if (start) begin
            dvs_q    <= mag_b;
            // divide by zero keeps the all-ones quotient unsigned
            neg_q    <= op_signed && (rs1_v[31] ^ rs2_v[31]) && (rs2_v != 32'd0);
            neg_r    <= op_signed && rs1_v[31];
            is_rem_q <= (funct3 == md_rem) || (funct3 == md_remu);
        end
    end

    // min int / -1 wraps back to the dividend with zero remainder
    assign rd_v  = is_rem_q ? (neg_r ? -rem_q : rem_q) : (neg_q ? -quo_q : quo_q);
    assign valid = done;

endmodule

// ==== verilog/fu_mult.sv ====
module fu_mult
import rv32i_types::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic        cancel,
    input  logic [31:0] rs1_v,
    input  logic [31:0] rs2_v,
    input  muldiv_f3_e  funct3,
    output logic [31:0] rd_v,
    output logic        valid
);

    logic               a_signed;
    logic               b_signed;
    logic signed [32:0] a_ext;
    logic signed [32:0] b_ext;
    logic [3:0]         stage_valid;
    muldiv_f3_e         op_s1;
    muldiv_f3_e         op_s2;
    muldiv_f3_e         op_s3;
    muldiv_f3_e         op_s4;
    logic signed [32:0] a_s1;
    logic signed [32:0] b_s1;
    logic signed [49:0] lo_s2;
    logic signed [49:0] hi_s2;
    logic signed [65:0] lo_s3;
    logic signed [65:0] hi_s3;
    logic [65:0]        prod_s4;

    // mulhsu treats only rs1 as signed
    assign a_signed = (funct3 == md_mulh) || (funct3 == md_mulhsu);
    assign b_signed = (funct3 == md_mulh);
    assign a_ext    = {a_signed & rs1_v[31], rs1_v};
    assign b_ext    = {b_signed & rs2_v[31], rs2_v};

    always_ff @(posedge clk) begin
        if (rst || cancel) begin
            stage_valid <= '0;
        end else begin
            stage_valid <= {stage_valid[2:0], start};
        end
    end

    always_ff @(posedge clk) begin
        a_s1  <= a_ext;
        b_s1  <= b_ext;
        op_s1 <= funct3;
        // split rs2 into an unsigned low half and a signed high half
        lo_s2 <= a_s1 * $signed({1'b0, b_s1[15:0]});
        hi_s2 <= a_s1 * $signed(b_s1[32:16]);
        op_s2 <= op_s1;
        // align the high partial product
        lo_s3 <= lo_s2;
        hi_s3 <= {hi_s2, 16'h0000};
        op_s3 <= op_s2;
        prod_s4 <= lo_s3 + hi_s3;
        op_s4   <= op_s3;
    end

    assign rd_v  = (op_s4 == md_mul) ? prod_s4[31:0] : prod_s4[63:32];
    assign valid = stage_valid[3];

endmodule

// ==== verilog/fu_alu.sv ====
module fu_alu
import rv32i_types::*;
(
    input  issue_t      issue,
    input  logic        start,
    output logic [31:0] rd_v,
    output logic        valid
);

    rv_opcode_e  opcode;
    alu_f3_e     funct3;
    logic        alt;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] u_imm;
    logic [31:0] sra_v;

    assign opcode = rv_opcode_e'(issue.decode_info.inst[6:0]);
    assign funct3 = alu_f3_e'(issue.decode_info.inst[14:12]);
    // funct7[5] selects sub and sra
    assign alt    = issue.decode_info.inst[30];
    assign u_imm  = {issue.decode_info.inst[31:12], 12'h000};

    assign a = issue.rs1_v;
    // op-imm replaces rs2 with the i-type immediate
    assign b = (opcode == op_imm) ? issue.decode_info.i_imm : issue.rs2_v;

    assign sra_v = $signed(a) >>> b[4:0];

    always_comb begin
        case (opcode)
            op_lui:   rd_v = u_imm;
            op_auipc: rd_v = issue.decode_info.pc + u_imm;
            default: begin
                case (funct3)
                    alu_add:  rd_v = (opcode == op_reg && alt) ? a - b : a + b;
                    alu_sll:  rd_v = a << b[4:0];
                    alu_slt:  rd_v = {31'b0, $signed(a) < $signed(b)};
                    alu_sltu: rd_v = {31'b0, a < b};
                    alu_xor:  rd_v = a ^ b;
                    alu_sr:   rd_v = alt ? sra_v : a >> b[4:0];
                    alu_or:   rd_v = a | b;
                    alu_and:  rd_v = a & b;
                    default:  rd_v = '0;
                endcase
            end
        endcase
    end

    // single cycle, result ready with the start
    assign valid = start;

endmodule

// ==== verilog/rv32i_types.sv ====
`include "exec_consts.svh"

package rv32i_types;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv_opcode_e;

    typedef enum logic [2:0] {
        alu_add  = 3'b000,
        alu_sll  = 3'b001,
        alu_slt  = 3'b010,
        alu_sltu = 3'b011,
        alu_xor  = 3'b100,
        alu_sr   = 3'b101,
        alu_or   = 3'b110,
        alu_and  = 3'b111
    } alu_f3_e;

    typedef enum logic [2:0] {
        md_mul    = 3'b000,
        md_mulh   = 3'b001,
        md_mulhsu = 3'b010,
        md_mulhu  = 3'b011,
        md_div    = 3'b100,
        md_divu   = 3'b101,
        md_rem    = 3'b110,
        md_remu   = 3'b111
    } muldiv_f3_e;

    typedef enum logic [2:0] {
        br_beq  = 3'b000,
        br_bne  = 3'b001,
        br_blt  = 3'b100,
        br_bge  = 3'b101,
        br_bltu = 3'b110,
        br_bgeu = 3'b111
    } branch_f3_e;

    // store widths share the low encodings
    typedef enum logic [2:0] {
        mem_b  = 3'b000,
        mem_h  = 3'b001,
        mem_w  = 3'b010,
        mem_bu = 3'b100,
        mem_hu = 3'b101
    } mem_f3_e;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] i_imm;
        logic [31:0] s_imm;
        logic [31:0] b_imm;
    } decode_info_t;

    typedef struct packed {
        logic [31:0]                rs1_v;
        logic [31:0]                rs2_v;
        decode_info_t               decode_info;
        logic [`ROB_ADDR_WIDTH-1:0] rob_idx;
        logic [`PHYS_REG_BITS-1:0]  pd;
        logic [`ARCH_REG_BITS-1:0]  rd;
    } issue_t;

    typedef struct packed {
        logic                       valid;
        logic [`ROB_ADDR_WIDTH-1:0] rob_idx;
        logic [`PHYS_REG_BITS-1:0]  pd;
        logic [`ARCH_REG_BITS-1:0]  rd;
        logic [31:0]                rd_v;
        logic [31:0]                inst;
        logic                       pc_select;
        logic [31:0]                pc_branch;
    } cdb_t;

    typedef struct packed {
        logic                      valid;
        logic [31:0]               addr;
        logic [31:0]               wdata;
        logic [3:0]                wmask;
        logic                      store;
        logic [`MEM_IDX_WIDTH-1:0] mem_idx;
    } mem_req_t;

endpackage

// ==== verilog/exec_consts.svh ====
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// reorder buffer index
`define ROB_ADDR_WIDTH 5

// physical and architectural register tags
`define PHYS_REG_BITS 6
`define ARCH_REG_BITS 5

// load/store queue
`define MEM_QUEUE_DEPTH 8
`define MEM_IDX_WIDTH $clog2(`MEM_QUEUE_DEPTH)

// start to valid, multiplier and divider
`define MULDIV_LATENCY 4

`endif
